/* source/fdd_pkg.sv */
/*
 * Shared types and constants for the floppy track cache.
 * Covers the SD buffer and drive bus widths, the track geometry
 * and the loader state encoding. Users refer to items by scoped name.
 */
`default_nettype none

package fdd_pkg;

	// ====================
	// Bus widths
	// ====================
	typedef logic [7:0]  byte_t;
	typedef logic [5:0]  track_num_t;
	typedef logic [3:0]  sector_idx_t;
	typedef logic [8:0]  sector_addr_t;
	// Sector index on top, sector offset below
	typedef logic [12:0] track_addr_t;
	typedef logic [31:0] lba_t;
	typedef logic [63:0] img_size_t;

	// ====================
	// Track geometry
	// ====================
	localparam int SECTORS_PER_TRACK = 13;
	// Request drops once this sector has started
	localparam int LAST_SECTOR       = 12;
	localparam int SECTOR_BYTES      = 512;
	localparam int TRACK_BYTES       = SECTORS_PER_TRACK * SECTOR_BYTES;

	// Per-drive loader FSM
	typedef enum logic [1:0] {
		LD_IDLE,
		LD_WRITE_BACK,
		LD_START_READ,
		LD_READ
	} loader_state_t;

endpackage

`default_nettype wire

/* source/reset_stretch.sv */
/*
 * Reset glue for the track cache.
 * Any reset request forces the core reset high and restarts a hold
 * counter. The core reset drops once the counter's top bit sets,
 * about 2**RESET_HOLD_LOG2 cycles after the last request.
 */
`timescale 1ns/1ps
`default_nettype none

module reset_stretch #(
	parameter int RESET_HOLD_LOG2 = 22
) (
	input  logic CLK_VIDEO,
	input  logic dd_reset,
	input  logic user_reset_i,
	output logic core_reset_o
);

	// One extra bit so the top bit marks the end of the hold
	logic [RESET_HOLD_LOG2:0] hold_cnt;
	logic                     reset_req;

	assign reset_req = dd_reset | user_reset_i;

	// Restarts on every request like the old 555 delay
	always_ff @(posedge CLK_VIDEO) begin
		if (reset_req) begin
			core_reset_o <= 1'b1;
			hold_cnt     <= '0;
		end else if (hold_cnt[RESET_HOLD_LOG2]) begin
			// Counter parks here until the next request
			core_reset_o <= 1'b0;
		end else begin
			hold_cnt <= hold_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/track_buffer.sv */
/*
 * Track buffer for one drive, 13 sectors of 512 bytes.
 * Port A faces the SD host, port B faces the drive controller.
 * Both ports have registered read data, one cycle after the address.
 */
`timescale 1ns/1ps
`default_nettype none

module track_buffer (
	input  logic                 CLK_VIDEO,
	// SD host side
	input  fdd_pkg::track_addr_t sd_addr_i,
	input  logic                 sd_we_i,
	input  fdd_pkg::byte_t       sd_wdata_i,
	output fdd_pkg::byte_t       sd_rdata_o,
	// Drive side
	input  fdd_pkg::track_addr_t drv_addr_i,
	input  logic                 drv_we_i,
	input  fdd_pkg::byte_t       drv_wdata_i,
	output fdd_pkg::byte_t       drv_rdata_o
);

	fdd_pkg::byte_t mem [fdd_pkg::TRACK_BYTES];

	// Read returns the old byte on a same-port write
	always_ff @(posedge CLK_VIDEO) begin
		if (sd_we_i) begin
			mem[sd_addr_i] <= sd_wdata_i;
		end
		sd_rdata_o <= mem[sd_addr_i];

		// Drive port wins on a same-address collision
		if (drv_we_i) begin
			mem[drv_addr_i] <= drv_wdata_i;
		end
		drv_rdata_o <= mem[drv_addr_i];
	end

endmodule

`default_nettype wire

/* source/track_loader.sv */
/*
 * Per-drive track loader.
 * On a mount or a track change it writes a dirty track back to its own
 * sectors, then reads the new track from the SD host sector by sector.
 * The CPU wait is held while a transfer is in flight.
 */
`timescale 1ns/1ps
`default_nettype none

module track_loader (
	input  logic                  CLK_VIDEO,
	input  logic                  reset_i,
	input  fdd_pkg::track_num_t   track_i,
	input  logic                  active_i,
	// Image mount from the host
	input  logic                  img_mounted_i,
	input  fdd_pkg::img_size_t    img_size_i,
	// SD host buffer
	input  logic                  sd_ack_i,
	input  fdd_pkg::sector_addr_t sd_buff_addr_i,
	input  logic                  sd_buff_wr_i,
	input  fdd_pkg::byte_t        sd_buff_dout_i,
	output fdd_pkg::byte_t        sd_buff_din_o,
	output fdd_pkg::lba_t         sd_lba_o,
	output logic                  sd_rd_o,
	output logic                  sd_wr_o,
	// Drive controller
	input  fdd_pkg::track_addr_t  drive_addr_i,
	input  logic                  drive_we_i,
	input  fdd_pkg::byte_t        drive_wdata_i,
	output fdd_pkg::byte_t        drive_rdata_o,
	output logic                  cpu_wait_o
);

	fdd_pkg::loader_state_t state;
	fdd_pkg::track_num_t    cur_track;
	fdd_pkg::sector_idx_t   track_sec;
	fdd_pkg::lba_t          lba;
	logic                   old_ack;
	logic                   ack_rise;
	logic                   ack_fall;
	logic                   dirty;
	logic                   mount_pend;
	logic                   img_present;
	logic                   start_op;
	logic                   drv_we;
	logic                   sd_we;
	fdd_pkg::track_addr_t   sd_addr;

	// First sector of a track
	function automatic fdd_pkg::lba_t track_lba(input fdd_pkg::track_num_t trk);
		return fdd_pkg::lba_t'(fdd_pkg::SECTORS_PER_TRACK) * fdd_pkg::lba_t'(trk);
	endfunction

	assign ack_rise = sd_ack_i & ~old_ack;
	assign ack_fall = ~sd_ack_i & old_ack;

	// New track asked for, or a mount whose pulse has ended
	assign start_op = (cur_track != track_i) || (mount_pend && !img_mounted_i);

	assign drv_we  = drive_we_i & active_i;
	assign sd_we   = sd_buff_wr_i & sd_ack_i;
	assign sd_addr = fdd_pkg::track_addr_t'({track_sec, sd_buff_addr_i});

	assign sd_lba_o = lba;

	// ====================
	// Loader FSM
	// ====================
	always_ff @(posedge CLK_VIDEO) begin
		old_ack <= sd_ack_i;

		if (reset_i) begin
			state       <= fdd_pkg::LD_IDLE;
			cur_track   <= '0;
			track_sec   <= '0;
			lba         <= '0;
			sd_rd_o     <= 1'b0;
			sd_wr_o     <= 1'b0;
			cpu_wait_o  <= 1'b0;
			dirty       <= 1'b0;
			mount_pend  <= 1'b0;
			img_present <= 1'b0;
		end else begin
			case (state)
			fdd_pkg::LD_IDLE: begin
				if (start_op) begin
					mount_pend <= 1'b0;
					if (img_present) begin
						if (dirty) begin
							// Save the old track before it is replaced
							dirty      <= 1'b0;
							track_sec  <= '0;
							lba        <= track_lba(cur_track);
							sd_wr_o    <= 1'b1;
							cpu_wait_o <= 1'b1;
							state      <= fdd_pkg::LD_WRITE_BACK;
						end else begin
							state <= fdd_pkg::LD_START_READ;
						end
					end
				end
			end

			fdd_pkg::LD_WRITE_BACK: begin
				if (ack_rise) begin
					if (track_sec >= fdd_pkg::sector_idx_t'(fdd_pkg::LAST_SECTOR)) begin
						sd_wr_o <= 1'b0;
					end
					lba <= lba + 1'b1;
				end else if (ack_fall) begin
					track_sec <= track_sec + 1'b1;
					if (!sd_wr_o) begin
						state <= fdd_pkg::LD_START_READ;
					end
				end
			end

			fdd_pkg::LD_START_READ: begin
				cur_track  <= track_i;
				track_sec  <= '0;
				lba        <= track_lba(track_i);
				sd_rd_o    <= 1'b1;
				cpu_wait_o <= 1'b1;
				state      <= fdd_pkg::LD_READ;
			end

			fdd_pkg::LD_READ: begin
				if (ack_rise) begin
					if (track_sec >= fdd_pkg::sector_idx_t'(fdd_pkg::LAST_SECTOR)) begin
						sd_rd_o <= 1'b0;
					end
					lba <= lba + 1'b1;
				end else if (ack_fall) begin
					track_sec <= track_sec + 1'b1;
					// Release the CPU after the last sector
					if (!sd_rd_o) begin
						cpu_wait_o <= 1'b0;
						state      <= fdd_pkg::LD_IDLE;
					end
				end
			end

			default: state <= fdd_pkg::LD_IDLE;
			endcase

			// A drive write marks the track for write-back
			if (drv_we) begin
				dirty <= 1'b1;
			end

			if (img_mounted_i) begin
				mount_pend  <= 1'b1;
				img_present <= (img_size_i != '0);
			end
		end
	end

	track_buffer u_buffer (
		.CLK_VIDEO   (CLK_VIDEO),
		.sd_addr_i   (sd_addr),
		.sd_we_i     (sd_we),
		.sd_wdata_i  (sd_buff_dout_i),
		.sd_rdata_o  (sd_buff_din_o),
		.drv_addr_i  (drive_addr_i),
		.drv_we_i    (drv_we),
		.drv_wdata_i (drive_wdata_i),
		.drv_rdata_o (drive_rdata_o)
	);

endmodule

`default_nettype wire

/* source/fdd_track_cache.sv */
/*
 * Two-drive floppy track cache.
 * Holds one loader and track buffer per drive, the reset stretcher,
 * the read data select and the merged wait and LED lines.
 */
`timescale 1ns/1ps
`default_nettype none

module fdd_track_cache #(
	parameter int RESET_HOLD_LOG2 = 22
) (
	input  logic                  CLK_VIDEO,
	input  logic                  dd_reset,
	input  logic                  user_reset_i,
	// Head position from the Disk II logic
	input  fdd_pkg::track_num_t   track0_i,
	input  fdd_pkg::track_num_t   track1_i,
	input  logic [1:0]            drive_active_i,
	// SD host
	input  logic [1:0]            img_mounted_i,
	input  fdd_pkg::img_size_t    img_size_i,
	input  logic [1:0]            sd_ack_i,
	input  fdd_pkg::sector_addr_t sd_buff_addr_i,
	input  logic                  sd_buff_wr_i,
	input  fdd_pkg::byte_t        sd_buff_dout_i,
	output fdd_pkg::byte_t        sd_buff_din0_o,
	output fdd_pkg::byte_t        sd_buff_din1_o,
	output fdd_pkg::lba_t         sd_lba0_o,
	output fdd_pkg::lba_t         sd_lba1_o,
	output logic [1:0]            sd_rd_o,
	output logic [1:0]            sd_wr_o,
	// Drive data bus
	input  fdd_pkg::track_addr_t  drive_addr_i,
	input  logic                  drive_we_i,
	input  fdd_pkg::byte_t        drive_wdata_i,
	output fdd_pkg::byte_t        drive_rdata_o,
	output logic                  cpu_wait_o,
	output logic                  disk_led_o
);

	logic           core_reset;
	logic           cpu_wait_a;
	logic           cpu_wait_b;
	fdd_pkg::byte_t rdata_a;
	fdd_pkg::byte_t rdata_b;

	reset_stretch #(
		.RESET_HOLD_LOG2 (RESET_HOLD_LOG2)
	) u_reset (
		.CLK_VIDEO    (CLK_VIDEO),
		.dd_reset     (dd_reset),
		.user_reset_i (user_reset_i),
		.core_reset_o (core_reset)
	);

	// ====================
	// Drive loaders
	// ====================
	track_loader u_loader_a (
		.CLK_VIDEO      (CLK_VIDEO),
		.reset_i        (core_reset),
		.track_i        (track0_i),
		.active_i       (drive_active_i[0]),
		.img_mounted_i  (img_mounted_i[0]),
		.img_size_i     (img_size_i),
		.sd_ack_i       (sd_ack_i[0]),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_din_o  (sd_buff_din0_o),
		.sd_lba_o       (sd_lba0_o),
		.sd_rd_o        (sd_rd_o[0]),
		.sd_wr_o        (sd_wr_o[0]),
		.drive_addr_i   (drive_addr_i),
		.drive_we_i     (drive_we_i),
		.drive_wdata_i  (drive_wdata_i),
		.drive_rdata_o  (rdata_a),
		.cpu_wait_o     (cpu_wait_a)
	);

	track_loader u_loader_b (
		.CLK_VIDEO      (CLK_VIDEO),
		.reset_i        (core_reset),
		.track_i        (track1_i),
		.active_i       (drive_active_i[1]),
		.img_mounted_i  (img_mounted_i[1]),
		.img_size_i     (img_size_i),
		.sd_ack_i       (sd_ack_i[1]),
		.sd_buff_addr_i (sd_buff_addr_i),
		.sd_buff_wr_i   (sd_buff_wr_i),
		.sd_buff_dout_i (sd_buff_dout_i),
		.sd_buff_din_o  (sd_buff_din1_o),
		.sd_lba_o       (sd_lba1_o),
		.sd_rd_o        (sd_rd_o[1]),
		.sd_wr_o        (sd_wr_o[1]),
		.drive_addr_i   (drive_addr_i),
		.drive_we_i     (drive_we_i),
		.drive_wdata_i  (drive_wdata_i),
		.drive_rdata_o  (rdata_b),
		.cpu_wait_o     (cpu_wait_b)
	);

	// Drive 0 has priority when both are selected
	always_comb begin
		if (drive_active_i[0]) begin
			drive_rdata_o = rdata_a;
		end else if (drive_active_i[1]) begin
			drive_rdata_o = rdata_b;
		end else begin
			drive_rdata_o = 8'h00;
		end
	end

	assign cpu_wait_o = cpu_wait_a | cpu_wait_b;
	// LED follows either motor
	assign disk_led_o = drive_active_i[0] | drive_active_i[1];

endmodule

`default_nettype wire

/* verif/fdd_sd_model.sv */
/*
 * Behavioral SD host and image store for the track cache testbench.
 * Serves read and write requests of both drives one sector at a time,
 * keeps written-back bytes and logs every served LBA.
 */
`timescale 1ns/1ps
`default_nettype none

module fdd_sd_model (
	input  logic                  CLK_VIDEO,
	input  logic [1:0]            sd_rd_i,
	input  logic [1:0]            sd_wr_i,
	input  fdd_pkg::lba_t         sd_lba0_i,
	input  fdd_pkg::lba_t         sd_lba1_i,
	input  fdd_pkg::byte_t        sd_buff_din0_i,
	input  fdd_pkg::byte_t        sd_buff_din1_i,
	output logic [1:0]            sd_ack_o,
	output fdd_pkg::sector_addr_t sd_buff_addr_o,
	output logic                  sd_buff_wr_o,
	output fdd_pkg::byte_t        sd_buff_dout_o
);

	fdd_pkg::byte_t store [longint];
	fdd_pkg::lba_t  served_lba [$];
	logic           served_wr [$];

	// Written-back bytes override the image pattern
	function automatic fdd_pkg::byte_t image_byte(input fdd_pkg::lba_t lba, input int off);
		longint key;
		key = longint'(lba) * 512 + off;
		if (store.exists(key)) begin
			return store[key];
		end
		return fdd_pkg::byte_t'(7 * lba + off);
	endfunction

	function automatic int log_size();
		return served_lba.size();
	endfunction

	function automatic fdd_pkg::lba_t log_lba(input int idx);
		return served_lba[idx];
	endfunction

	function automatic logic log_wr(input int idx);
		return served_wr[idx];
	endfunction

	task automatic clear_log();
		served_lba.delete();
		served_wr.delete();
	endtask

	// One sector for drive d
	task automatic serve_sector(input int d);
		int            delay;
		logic          is_wr;
		fdd_pkg::lba_t lba;
		delay = ($urandom % 8) + 1;
		is_wr = sd_wr_i[d];
		repeat (delay) @(posedge CLK_VIDEO);
		lba = (d == 0) ? sd_lba0_i : sd_lba1_i;
		served_lba.push_back(lba);
		served_wr.push_back(is_wr);
		sd_ack_o[d] <= 1'b1;
		for (int i = 0; i < 512; i++) begin
			@(posedge CLK_VIDEO);
			sd_buff_addr_o <= fdd_pkg::sector_addr_t'(i);
			if (is_wr) begin
				// Buffer read data shows up one cycle after the address
				@(posedge CLK_VIDEO);
				@(negedge CLK_VIDEO);
				store[longint'(lba) * 512 + i] = (d == 0) ? sd_buff_din0_i : sd_buff_din1_i;
			end else begin
				sd_buff_dout_o <= image_byte(lba, i);
				sd_buff_wr_o   <= 1'b1;
			end
		end
		@(posedge CLK_VIDEO);
		sd_buff_wr_o <= 1'b0;
		sd_ack_o[d]  <= 1'b0;
	endtask

	initial begin
		sd_ack_o       = 2'b00;
		sd_buff_addr_o = '0;
		sd_buff_wr_o   = 1'b0;
		sd_buff_dout_o = '0;
		forever begin
			@(posedge CLK_VIDEO);
			if (sd_rd_i[0] | sd_wr_i[0]) begin
				serve_sector(0);
			end else if (sd_rd_i[1] | sd_wr_i[1]) begin
				serve_sector(1);
			end
		end
	end

endmodule

`default_nettype wire

/* verif/tb_fdd_track_cache.sv */
/*
 * Directed testbench for the two-drive floppy track cache.
 * Covers reset, mount and track loads, dirty write-back and the
 * drive read select, with a behavioral SD host.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_fdd_track_cache;

	localparam int RESET_HOLD_LOG2_TB = 4;
	localparam int CYCLES_PER_TEST    = 40000;
	localparam int NUM_TESTS          = 5;

	logic                  CLK_VIDEO;
	logic                  dd_reset;
	logic                  user_reset;
	fdd_pkg::track_num_t   track0;
	fdd_pkg::track_num_t   track1;
	logic [1:0]            drive_active;
	logic [1:0]            img_mounted;
	fdd_pkg::img_size_t    img_size;
	logic [1:0]            sd_ack;
	fdd_pkg::sector_addr_t sd_buff_addr;
	logic                  sd_buff_wr;
	fdd_pkg::byte_t        sd_buff_dout;
	fdd_pkg::byte_t        din0;
	fdd_pkg::byte_t        din1;
	fdd_pkg::lba_t         lba0;
	fdd_pkg::lba_t         lba1;
	logic [1:0]            sd_rd;
	logic [1:0]            sd_wr;
	fdd_pkg::track_addr_t  drive_addr;
	logic                  drive_we;
	fdd_pkg::byte_t        drive_wdata;
	fdd_pkg::byte_t        drive_rdata;
	logic                  cpu_wait;
	logic                  disk_led;

	// Bytes written into drive 0 track 0 keyed by track offset
	fdd_pkg::byte_t written [int];

	fdd_track_cache #(
		.RESET_HOLD_LOG2 (RESET_HOLD_LOG2_TB)
	) u_dut (
		.CLK_VIDEO (CLK_VIDEO), .dd_reset (dd_reset), .user_reset_i (user_reset),
		.track0_i (track0), .track1_i (track1), .drive_active_i (drive_active),
		.img_mounted_i (img_mounted), .img_size_i (img_size), .sd_ack_i (sd_ack),
		.sd_buff_addr_i (sd_buff_addr), .sd_buff_wr_i (sd_buff_wr),
		.sd_buff_dout_i (sd_buff_dout), .sd_buff_din0_o (din0), .sd_buff_din1_o (din1),
		.sd_lba0_o (lba0), .sd_lba1_o (lba1), .sd_rd_o (sd_rd), .sd_wr_o (sd_wr),
		.drive_addr_i (drive_addr), .drive_we_i (drive_we), .drive_wdata_i (drive_wdata),
		.drive_rdata_o (drive_rdata), .cpu_wait_o (cpu_wait), .disk_led_o (disk_led)
	);

	fdd_sd_model u_sd (
		.CLK_VIDEO (CLK_VIDEO), .sd_rd_i (sd_rd), .sd_wr_i (sd_wr),
		.sd_lba0_i (lba0), .sd_lba1_i (lba1),
		.sd_buff_din0_i (din0), .sd_buff_din1_i (din1),
		.sd_ack_o (sd_ack), .sd_buff_addr_o (sd_buff_addr),
		.sd_buff_wr_o (sd_buff_wr), .sd_buff_dout_o (sd_buff_dout)
	);

	initial begin
		CLK_VIDEO = 1'b0;
		forever #50 CLK_VIDEO = ~CLK_VIDEO;
	end

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLK_VIDEO);
		$display("Timeout: the tests did not finish in the allowed number of cycles");
		$display("TEST RESULT: FAIL");
		$fatal(1);
	end

	// ====================
	// Compare tasks
	// ====================
	task automatic check_byte(input string name, input fdd_pkg::byte_t exp,
			input fdd_pkg::byte_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %h, actual %h", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_lba(input string name, input fdd_pkg::lba_t exp,
			input fdd_pkg::lba_t act);
		if (exp !== act) begin
			$display("ERR %s: expected %0d, actual %0d", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("ERR %s: expected %b, actual %b", name, exp, act);
			$display("TEST RESULT: FAIL");
			$fatal(1);
		end
	endtask

	// Image pattern of a byte that was never written
	function automatic fdd_pkg::byte_t pattern(input int lba, input int off);
		return fdd_pkg::byte_t'(7 * lba + off);
	endfunction

	// Track 0 content of drive 0 after the writes
	function automatic fdd_pkg::byte_t track0_byte(input int addr);
		if (written.exists(addr)) begin
			return written[addr];
		end
		return pattern(addr / 512, addr % 512);
	endfunction

	task automatic read_drive(input int addr, output fdd_pkg::byte_t data);
		@(posedge CLK_VIDEO);
		drive_addr <= fdd_pkg::track_addr_t'(addr);
		@(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		data = drive_rdata;
	endtask

	task automatic write_drive(input int addr, input fdd_pkg::byte_t data);
		@(posedge CLK_VIDEO);
		drive_addr  <= fdd_pkg::track_addr_t'(addr);
		drive_wdata <= data;
		drive_we    <= 1'b1;
		@(posedge CLK_VIDEO);
		drive_we    <= 1'b0;
	endtask

	// Waits out one load and checks that the CPU wait spans it
	task automatic wait_load(input string name);
		do @(negedge CLK_VIDEO); while ((sd_rd | sd_wr) == 2'b00);
		check_bit(name, 1'b1, cpu_wait);
		do @(negedge CLK_VIDEO); while (cpu_wait);
		check_bit(name, 1'b0, |(sd_rd | sd_wr));
	endtask

	task automatic check_log(input string name, input int wr_base, input int n_wr,
			input int rd_base, input int n_rd);
		check_lba(name, n_wr + n_rd, u_sd.log_size());
		for (int i = 0; i < n_wr + n_rd; i++) begin
			check_bit(name, i < n_wr, u_sd.log_wr(i));
			check_lba(name, (i < n_wr) ? wr_base + i : rd_base + i - n_wr, u_sd.log_lba(i));
		end
	endtask

	task automatic mount_drive(input int d);
		@(posedge CLK_VIDEO);
		img_size       <= 64'd143360;
		img_mounted[d] <= 1'b1;
		@(posedge CLK_VIDEO);
		img_mounted    <= 2'b00;
	endtask

	// ====================
	// Directed tests
	// ====================
	task automatic test_reset();
		repeat ((2 ** RESET_HOLD_LOG2_TB) + 4) @(posedge CLK_VIDEO);
		@(negedge CLK_VIDEO);
		check_bit("test_reset", 1'b0, |sd_rd);
		check_bit("test_reset", 1'b0, |sd_wr);
		check_bit("test_reset", 1'b0, cpu_wait);
		@(posedge CLK_VIDEO);
		user_reset <= 1'b1;
		track0     <= 6'd3;
		@(posedge CLK_VIDEO);
		user_reset <= 1'b0;
		// Mount lands inside the reset hold and must be ignored
		mount_drive(0);
		repeat ((2 ** RESET_HOLD_LOG2_TB) - 1) begin
			@(negedge CLK_VIDEO);
			check_bit("test_reset", 1'b0, |(sd_rd | sd_wr));
		end
		@(posedge CLK_VIDEO);
		track0 <= 6'd0;
		repeat (8) @(posedge CLK_VIDEO);
	endtask

	task automatic test_mount_read();
		fdd_pkg::byte_t data;
		int             addr;
		u_sd.clear_log();
		mount_drive(0);
		wait_load("test_mount_read");
		check_log("test_mount_read", 0, 0, 0, 13);
		@(posedge CLK_VIDEO);
		drive_active <= 2'b01;
		repeat (40) begin
			addr = $urandom % fdd_pkg::TRACK_BYTES;
			read_drive(addr, data);
			check_byte("test_mount_read", pattern(addr / 512, addr % 512), data);
		end
	endtask

	task automatic test_second_drive();
		fdd_pkg::byte_t data;
		int             addr;
		u_sd.clear_log();
		@(posedge CLK_VIDEO);
		track1 <= 6'd5;
		mount_drive(1);
		wait_load("test_second_drive");
		check_log("test_second_drive", 0, 0, 65, 13);
		repeat (20) begin
			addr = $urandom % fdd_pkg::TRACK_BYTES;
			@(posedge CLK_VIDEO);
			drive_active <= 2'b10;
			read_drive(addr, data);
			check_byte("test_second_drive", pattern(65 + addr / 512, addr % 512), data);
			check_bit("test_second_drive", 1'b1, disk_led);
			@(posedge CLK_VIDEO);
			drive_active <= 2'b01;
			read_drive(addr, data);
			check_byte("test_second_drive", pattern(addr / 512, addr % 512), data);
			check_bit("test_second_drive", 1'b1, disk_led);
		end
	endtask

	task automatic test_write_back();
		fdd_pkg::byte_t data;
		int             addr;
		@(posedge CLK_VIDEO);
		drive_active <= 2'b01;
		repeat (20) begin
			addr          = $urandom % fdd_pkg::TRACK_BYTES;
			data          = fdd_pkg::byte_t'($urandom);
			written[addr] = data;
			write_drive(addr, data);
		end
		u_sd.clear_log();
		track0 <= 6'd2;
		wait_load("test_write_back");
		check_log("test_write_back", 0, 13, 26, 13);
		for (int a = 0; a < fdd_pkg::TRACK_BYTES; a++) begin
			check_byte("test_write_back", track0_byte(a), u_sd.image_byte(a / 512, a % 512));
		end
		u_sd.clear_log();
		@(posedge CLK_VIDEO);
		track0 <= 6'd0;
		wait_load("test_write_back");
		check_log("test_write_back", 0, 0, 0, 13);
		foreach (written[a]) begin
			read_drive(a, data);
			check_byte("test_write_back", written[a], data);
		end
	endtask

	task automatic test_select_mux();
		fdd_pkg::byte_t data;
		int             addr;
		addr = $urandom % fdd_pkg::TRACK_BYTES;
		@(posedge CLK_VIDEO);
		drive_active <= 2'b00;
		read_drive(addr, data);
		check_byte("test_select_mux", 8'h00, data);
		check_bit("test_select_mux", 1'b0, disk_led);
		@(posedge CLK_VIDEO);
		drive_active <= 2'b11;
		read_drive(addr, data);
		check_byte("test_select_mux", track0_byte(addr), data);
		check_bit("test_select_mux", 1'b1, disk_led);
		@(posedge CLK_VIDEO);
		drive_active <= 2'b10;
		write_drive(addr, 8'h5a);
		u_sd.clear_log();
		track0 <= 6'd4;
		wait_load("test_select_mux");
		check_log("test_select_mux", 0, 0, 52, 13);
		// Drive 1 is dirty and saves track 5 before reading track 6
		u_sd.clear_log();
		@(posedge CLK_VIDEO);
		track1 <= 6'd6;
		wait_load("test_select_mux");
		check_log("test_select_mux", 65, 13, 78, 13);
		for (int a = 0; a < fdd_pkg::TRACK_BYTES; a++) begin
			data = (a == addr) ? 8'h5a : pattern(65 + a / 512, a % 512);
			check_byte("test_select_mux", data, u_sd.image_byte(65 + a / 512, a % 512));
		end
	endtask

	initial begin
		int seed_dummy;
		seed_dummy   = $urandom(32'h670c);
		dd_reset     = 1'b1;
		user_reset   = 1'b0;
		track0       = '0;
		track1       = '0;
		drive_active = 2'b00;
		img_mounted  = 2'b00;
		img_size     = '0;
		drive_addr   = '0;
		drive_we     = 1'b0;
		drive_wdata  = '0;
		repeat (16) @(posedge CLK_VIDEO);
		dd_reset <= 1'b0;

		test_reset();
		test_mount_read();
		test_second_drive();
		test_write_back();
		test_select_mux();

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* fdd_track_cache.f */
source/fdd_pkg.sv
source/reset_stretch.sv
source/track_buffer.sv
source/track_loader.sv
source/fdd_track_cache.sv
verif/fdd_sd_model.sv
verif/tb_fdd_track_cache.sv

/* Bender.yml */
package:
  name: fdd_track_cache

sources:
  - target: rtl
    files:
      - source/fdd_pkg.sv
      - source/reset_stretch.sv
      - source/track_buffer.sv
      - source/track_loader.sv
      - source/fdd_track_cache.sv
  - target: verif
    files:
      - source/fdd_pkg.sv
      - source/reset_stretch.sv
      - source/track_buffer.sv
      - source/track_loader.sv
      - source/fdd_track_cache.sv
      - verif/fdd_sd_model.sv
      - verif/tb_fdd_track_cache.sv
